/* hw/game_ctrl.sv */
`timescale 1ns/10ps

module game_ctrl import shooter_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coord_t x_i,
    input  coord_t y_i,
    input  key_t   key_i,
    input  logic   all_clear_i,
    output logic   frame_tick_o,
    output logic   game_stop_o,
    output logic   score_clr_o,
    output logic   game_over_o
);

    game_state_t state_q;
    game_state_t state_d;

    logic start;

    assign start = key_i[KEY_START_BIT];

    // last pixel of the frame
    assign frame_tick_o = (x_i == MAX_X - 10'd1) && (y_i == MAX_Y - 10'd1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_NEWGAME: begin
                if (start) begin
                    state_d = ST_PLAY;
                end
            end
            ST_PLAY: begin
                if (all_clear_i) begin
                    state_d = ST_OVER;  // every target down
                end
            end
            ST_OVER: begin
                if (start) begin
                    state_d = ST_NEWGAME;
                end
            end
            default: state_d = ST_NEWGAME;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_NEWGAME;
        end else begin
            state_q <= state_d;
        end
    end

    assign game_stop_o = state_q != ST_PLAY;  // objects frozen at start values
    assign score_clr_o = state_q == ST_NEWGAME;
    assign game_over_o = state_q == ST_OVER;

endmodule

/* hw/gun_ctrl.sv */
`timescale 1ns/10ps

module gun_ctrl import shooter_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   game_stop_i,
    input  logic   frame_tick_i,
    input  key_t   key_i,
    output coord_t gun_x_o
);

    coord_t gun_x_q;  // left edge of the gun

    logic can_right;
    logic can_left;

    // step only if the whole gun stays on screen afterwards
    assign can_right = (gun_x_q + GUN_X_SIZE + GUN_V) <= MAX_X;
    assign can_left  = gun_x_q >= GUN_V;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gun_x_q <= GUN_X_START;
        end else if (game_stop_i) begin
            gun_x_q <= GUN_X_START;  // parked in the middle
        end else if (frame_tick_i) begin
            if (key_i == KEY_RIGHT && can_right) begin
                gun_x_q <= gun_x_q + GUN_V;
            end else if (key_i == KEY_LEFT && can_left) begin
                gun_x_q <= gun_x_q - GUN_V;
            end
        end
    end

    assign gun_x_o = gun_x_q;

endmodule

/* hw/pixel_mux.sv */
`timescale 1ns/10ps

module pixel_mux import shooter_pkg::*; (
    input  coord_t       x_i,
    input  coord_t       y_i,
    input  coord_t       gun_x_i,
    input  coord_t       shot_x_i,
    input  coord_t       shot_y_i,
    input  target_mask_t target_alive_i,
    output rgb_t         rgb_o
);

    logic shot_on;
    logic gun_on;
    logic target_on;

    assign shot_on = (x_i >= shot_x_i) && (x_i <= shot_x_i + SHOT_SIZE - 10'd1)
                  && (y_i >= shot_y_i) && (y_i <= shot_y_i + SHOT_SIZE - 10'd1);

    assign gun_on = (x_i >= gun_x_i) && (x_i <= gun_x_i + GUN_X_SIZE - 10'd1)
                 && (y_i >= GUN_Y_T) && (y_i <= GUN_Y_B);

    // any live square under the beam
    always_comb begin
        target_on = 1'b0;
        for (int i = 0; i < NUM_TARGETS; i++) begin
            if (target_alive_i[i]
                && x_i >= TARGET_X[i % NUM_COLS]
                && x_i <= TARGET_X[i % NUM_COLS] + TARGET_SIZE - 10'd1
                && y_i >= TARGET_Y[i]
                && y_i <= TARGET_Y[i] + TARGET_SIZE - 10'd1) begin
                target_on = 1'b1;
            end
        end
    end

    // shot drawn over the gun it sits in
    always_comb begin
        if (shot_on) begin
            rgb_o = COL_RED;
        end else if (gun_on) begin
            rgb_o = COL_WHITE;
        end else if (target_on) begin
            rgb_o = COL_RED;
        end else begin
            rgb_o = COL_BLACK;  // background
        end
    end

endmodule

/* hw/score_counter.sv */
`timescale 1ns/10ps

module score_counter import shooter_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic clr_i,
    input  logic inc_i,
    output bcd_t tens_o,
    output bcd_t ones_o
);

    bcd_t tens_q;
    bcd_t ones_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tens_q <= 4'd0;
            ones_q <= 4'd0;
        end else if (clr_i) begin
            tens_q <= 4'd0;
            ones_q <= 4'd0;
        end else if (inc_i) begin
            if (ones_q == 4'd9) begin
                ones_q <= 4'd0;
                // carry into tens, 99 wraps to 00
                tens_q <= (tens_q == 4'd9) ? 4'd0 : tens_q + 4'd1;
            end else begin
                ones_q <= ones_q + 4'd1;
            end
        end
    end

    assign tens_o = tens_q;
    assign ones_o = ones_q;

endmodule

/* hw/shooter_pkg.sv */
package shooter_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate
    typedef logic [2:0] rgb_t;
    typedef logic [3:0] bcd_t;    // one decimal digit
    typedef logic [4:0] key_t;

    localparam int NUM_TARGETS = 12;
    localparam int NUM_COLS    = 6;  // targets per row

    typedef logic [NUM_TARGETS-1:0] target_mask_t;  // one alive bit per target

    typedef enum logic [1:0] {
        ST_NEWGAME,
        ST_PLAY,
        ST_OVER
    } game_state_t;

    // screen
    localparam coord_t MAX_X = 10'd640;
    localparam coord_t MAX_Y = 10'd480;

    // gun rows and size
    localparam coord_t GUN_Y_T     = 10'd420;
    localparam coord_t GUN_Y_B     = 10'd470;
    localparam coord_t GUN_X_SIZE  = 10'd60;
    localparam coord_t GUN_V       = 10'd4;
    localparam coord_t GUN_X_START = 10'd290;  // centred

    // shot
    localparam coord_t SHOT_SIZE    = 10'd6;
    localparam coord_t SHOT_V       = 10'd5;
    localparam coord_t MUZZLE_DX    = 10'd29;  // gun left edge to shot left edge
    localparam coord_t SHOT_Y_START = 10'd445;

    localparam coord_t TARGET_SIZE = 10'd30;

    // left edges by column, top edges by target index
    localparam coord_t [0:NUM_COLS-1] TARGET_X = {
        10'd40, 10'd140, 10'd240, 10'd340, 10'd440, 10'd540
    };
    localparam coord_t [0:NUM_TARGETS-1] TARGET_Y = {
        10'd40,  10'd40,  10'd40,  10'd40,  10'd40,  10'd40,
        10'd110, 10'd110, 10'd110, 10'd110, 10'd110, 10'd110
    };

    // key codes
    localparam key_t KEY_RIGHT     = 5'h11;
    localparam key_t KEY_LEFT      = 5'h13;
    localparam key_t KEY_FIRE      = 5'h15;
    localparam int   KEY_START_BIT = 4;

    localparam rgb_t COL_WHITE = 3'b111;
    localparam rgb_t COL_RED   = 3'b100;
    localparam rgb_t COL_BLACK = 3'b000;

endpackage

/* hw/shooter_top.sv */
`timescale 1ns/10ps

module shooter_top import shooter_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coord_t x_i,
    input  coord_t y_i,
    input  key_t   key_i,
    output rgb_t   rgb_o,
    output bcd_t   score_tens_o,
    output bcd_t   score_ones_o,
    output logic   game_over_o
);

    logic         frame_tick;
    logic         game_stop;
    logic         score_clr;
    coord_t       gun_x;
    coord_t       shot_x;
    coord_t       shot_y;
    target_mask_t target_alive;
    logic         hit;
    logic         all_clear;

    game_ctrl u_game_ctrl (
        .clk          (clk),
        .rst          (rst),
        .x_i          (x_i),
        .y_i          (y_i),
        .key_i        (key_i),
        .all_clear_i  (all_clear),
        .frame_tick_o (frame_tick),
        .game_stop_o  (game_stop),
        .score_clr_o  (score_clr),
        .game_over_o  (game_over_o)
    );

    gun_ctrl u_gun_ctrl (
        .clk          (clk),
        .rst          (rst),
        .game_stop_i  (game_stop),
        .frame_tick_i (frame_tick),
        .key_i        (key_i),
        .gun_x_o      (gun_x)
    );

    shot_ctrl u_shot_ctrl (
        .clk          (clk),
        .rst          (rst),
        .game_stop_i  (game_stop),
        .frame_tick_i (frame_tick),
        .key_i        (key_i),
        .gun_x_i      (gun_x),
        .shot_x_o     (shot_x),
        .shot_y_o     (shot_y)
    );

    target_field u_target_field (
        .clk            (clk),
        .rst            (rst),
        .game_stop_i    (game_stop),
        .shot_x_i       (shot_x),
        .shot_y_i       (shot_y),
        .target_alive_o (target_alive),
        .hit_o          (hit),
        .all_clear_o    (all_clear)
    );

    // one point per target
    score_counter u_score_counter (
        .clk    (clk),
        .rst    (rst),
        .clr_i  (score_clr),
        .inc_i  (hit),
        .tens_o (score_tens_o),
        .ones_o (score_ones_o)
    );

    pixel_mux u_pixel_mux (
        .x_i            (x_i),
        .y_i            (y_i),
        .gun_x_i        (gun_x),
        .shot_x_i       (shot_x),
        .shot_y_i       (shot_y),
        .target_alive_i (target_alive),
        .rgb_o          (rgb_o)
    );

endmodule

/* hw/shot_ctrl.sv */
`timescale 1ns/10ps

module shot_ctrl import shooter_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   game_stop_i,
    input  logic   frame_tick_i,
    input  key_t   key_i,
    input  coord_t gun_x_i,
    output coord_t shot_x_o,
    output coord_t shot_y_o
);

    coord_t shot_x_q;  // left edge
    coord_t shot_y_q;  // top edge

    logic fire;
    logic at_top;

    assign fire   = key_i == KEY_FIRE;
    assign at_top = shot_y_q < SHOT_V;  // next step would leave the screen

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shot_x_q <= GUN_X_START + MUZZLE_DX;
            shot_y_q <= SHOT_Y_START;
        end else if (game_stop_i) begin
            shot_x_q <= GUN_X_START + MUZZLE_DX;
            shot_y_q <= SHOT_Y_START;
        end else if (frame_tick_i) begin
            if (fire && !at_top) begin
                shot_y_q <= shot_y_q - SHOT_V;  // x stays where it was launched
            end else begin
                // reload at the muzzle of the gun
                shot_x_q <= gun_x_i + MUZZLE_DX;
                shot_y_q <= SHOT_Y_START;
            end
        end
    end

    assign shot_x_o = shot_x_q;
    assign shot_y_o = shot_y_q;

endmodule

/* hw/target_field.sv */
`timescale 1ns/10ps

module target_field import shooter_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         game_stop_i,
    input  coord_t       shot_x_i,
    input  coord_t       shot_y_i,
    output target_mask_t target_alive_o,
    output logic         hit_o,
    output logic         all_clear_o
);

    target_mask_t alive_q;
    target_mask_t hit_vec;  // targets under the shot this cycle

    coord_t shot_x_r;
    coord_t shot_y_b;

    assign shot_x_r = shot_x_i + SHOT_SIZE - 10'd1;
    assign shot_y_b = shot_y_i + SHOT_SIZE - 10'd1;

    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_target
        localparam coord_t TX = TARGET_X[i % NUM_COLS];
        localparam coord_t TY = TARGET_Y[i];

        logic in_col;
        logic in_row;

        // shot fully inside the column
        assign in_col = (shot_x_i >= TX) && (shot_x_r <= TX + TARGET_SIZE - 10'd1);
        // any vertical overlap counts
        assign in_row = (shot_y_i <= TY + TARGET_SIZE - 10'd1) && (shot_y_b >= TY);

        assign hit_vec[i] = alive_q[i] && in_col && in_row;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alive_q <= '1;
        end else if (game_stop_i) begin
            alive_q <= '1;  // full field between games
        end else begin
            alive_q <= alive_q & ~hit_vec;
        end
    end

    // at most one bit of hit_vec is set, see column spacing
    assign hit_o          = |hit_vec;
    assign all_clear_o    = ~|alive_q;
    assign target_alive_o = alive_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_shooter -f shooter.f || exit 1
sim_out="$(./obj_dir/Vtb_shooter 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All tests passed" && exit 0 || exit 1

/* shooter.f */
+incdir+tb
hw/shooter_pkg.sv
hw/game_ctrl.sv
hw/gun_ctrl.sv
hw/shot_ctrl.sv
hw/target_field.sv
hw/score_counter.sv
hw/pixel_mux.sv
hw/shooter_top.sv
tb/tb_shooter.sv

/* tb/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one cycle at the last pixel of the frame, key held only in that cycle
task automatic frame_tick(input key_t key);
    @(posedge clk);
    #5;
    x_i   = coord_t'(639);
    y_i   = coord_t'(479);
    key_i = key;
    @(posedge clk);
    #5;
    x_i   = '0;
    y_i   = '0;
    key_i = 5'h00;
endtask

task automatic press_start();
    @(posedge clk);
    #5;
    key_i = 5'h10;  // start bit alone
    @(posedge clk);
    #5;
    key_i = 5'h00;
endtask

// colour is combinational, sampled well inside the cycle
task automatic probe_pixel(input int px, input int py, output int seen);
    @(posedge clk);
    #5;
    x_i = coord_t'(px);
    y_i = coord_t'(py);
    #20;
    seen = int'(rgb_o);
endtask

task automatic wait_score(input int target, input int max_cycles);
    int n;
    int seen;
    seen = 10 * int'(score_tens_o) + int'(score_ones_o);
    for (n = 0; n < max_cycles && seen != target; n++) begin
        @(posedge clk);
        #5;
        seen = 10 * int'(score_tens_o) + int'(score_ones_o);
    end
    if (seen != target) begin
        report_failure($sformatf("timeout: score stuck at %0d while waiting for %0d",
                                 seen, target));
    end
endtask

task automatic wait_game_over(input int max_cycles);
    int n;
    for (n = 0; n < max_cycles && game_over_o !== 1'b1; n++) begin
        @(posedge clk);
        #5;
    end
    if (game_over_o !== 1'b1) begin
        report_failure("timeout: game over flag never rose after the field was cleared");
    end
endtask

`endif

/* tb/tb_shooter.sv */
`timescale 1ns/10ps

module tb_shooter import shooter_pkg::*; ();

    logic   clk;
    logic   rst;
    coord_t x_i;
    coord_t y_i;
    key_t   key_i;
    rgb_t   rgb_o;
    bcd_t   score_tens_o;
    bcd_t   score_ones_o;
    logic   game_over_o;

    // expected game state
    int        gun_exp;     // gun left edge
    int        shot_y_exp;  // shot top edge
    bit [11:0] alive_exp;
    int        score_exp;

    shooter_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .x_i          (x_i),
        .y_i          (y_i),
        .key_i        (key_i),
        .rgb_o        (rgb_o),
        .score_tens_o (score_tens_o),
        .score_ones_o (score_ones_o),
        .game_over_o  (game_over_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    `include "tb_tasks.svh"

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            report_failure($sformatf("FAIL %s: expected %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_pixel(input string name, input int px, input int py,
                               input rgb_t expected);
        int seen;
        probe_pixel(px, py, seen);
        check_value($sformatf("%s at (%0d,%0d)", name, px, py), int'(expected), seen);
    endtask

    task automatic check_score();
        wait_score(score_exp, 20);
        check_value("score tens", score_exp / 10, int'(score_tens_o));
        check_value("score ones", score_exp % 10, int'(score_ones_o));
    endtask

    // a step that would push the gun past either screen edge is skipped
    function automatic int gun_step(input int x, input int dir);
        if (dir > 0 && x + 4 + 60 <= 640) begin
            return x + 4;
        end else if (dir < 0 && x - 4 >= 0) begin
            return x - 4;
        end
        return x;
    endfunction

    // probe the left part of the body only since the shot may trail the muzzle by a step
    task automatic check_gun();
        int off;
        off = $urandom % 21;
        check_pixel("gun body", gun_exp + off, 445, COL_WHITE);
        check_pixel("gun right edge", gun_exp + 59, 460, COL_WHITE);
        if (gun_exp + 60 < 640) begin
            check_pixel("right of gun", gun_exp + 60, 460, COL_BLACK);
        end
        if (gun_exp > 0) begin
            check_pixel("left of gun", gun_exp - 1, 460, COL_BLACK);
        end
    endtask

    task automatic check_targets();
        int i;
        for (i = 0; i < 12; i++) begin
            check_pixel($sformatf("target %0d", i), 40 + 100 * (i % 6) + 10 + $urandom % 20,
                        ((i < 6) ? 40 : 110) + $urandom % 30,
                        alive_exp[i] ? COL_RED : COL_BLACK);
        end
    endtask

    task automatic move_gun(input int target);
        int n;
        for (n = 0; n < 200 && gun_exp != target; n++) begin
            if (target > gun_exp) begin
                frame_tick(KEY_RIGHT);
                gun_exp = gun_step(gun_exp, 1);
            end else begin
                frame_tick(KEY_LEFT);
                gun_exp = gun_step(gun_exp, -1);
            end
        end
        check_gun();
        frame_tick(5'h00);  // reload at the new muzzle
        shot_y_exp = 445;
    endtask

    task automatic clear_column(input int col);
        int k;
        int row;
        int idx;
        int tx;
        int ty;
        tx = 40 + 100 * col;
        move_gun(tx + 3 - 29);  // shot lands 3 px inside the column
        check_pixel("shot at muzzle", tx + 3 + $urandom % 6, 447, COL_RED);
        for (k = 1; k <= 76; k++) begin
            frame_tick(KEY_FIRE);
            shot_y_exp = 445 - 5 * k;
            for (row = 1; row >= 0; row--) begin
                idx = col + 6 * row;
                ty  = (row == 1) ? 110 : 40;
                if (alive_exp[idx] && shot_y_exp <= ty + 29 && shot_y_exp + 5 >= ty) begin
                    alive_exp[idx] = 1'b0;
                    score_exp++;
                    check_score();
                    // probe clear of the shot column
                    check_pixel($sformatf("target %0d hit", idx), tx + 10 + $urandom % 20,
                                ty + $urandom % 30, COL_BLACK);
                end
            end
        end
        frame_tick(5'h00);
    endtask

    initial begin
        int k;
        void'($urandom(32'hc1e1));
        rst        = 1'b1;
        x_i        = '0;
        y_i        = '0;
        key_i      = 5'h00;
        gun_exp    = 290;
        shot_y_exp = 445;
        alive_exp  = '1;
        score_exp  = 0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        check_score();
        check_value("game over after reset", 0, int'(game_over_o));
        check_pixel("gun", 300, 445, COL_WHITE);
        check_pixel("shot over gun", 320, 445, COL_RED);
        check_pixel("background", 5, 5, COL_BLACK);
        check_targets();

        press_start();
        // fly between columns, through the top and back up again
        for (k = 1; k <= 96; k++) begin
            frame_tick(KEY_FIRE);
            shot_y_exp = (shot_y_exp >= 5) ? shot_y_exp - 5 : 445;
            check_pixel("shot in flight", 319 + $urandom % 6, shot_y_exp + $urandom % 6, COL_RED);
        end
        frame_tick(5'h00);
        shot_y_exp = 445;
        check_pixel("shot reloaded", 321, 447, COL_RED);
        check_pixel("old shot gone", 321, 417, COL_BLACK);

        for (k = 0; k < 75; k++) begin
            frame_tick(KEY_RIGHT);
            gun_exp = gun_step(gun_exp, 1);
            check_gun();
        end
        for (k = 0; k < 150; k++) begin
            frame_tick(KEY_LEFT);
            gun_exp = gun_step(gun_exp, -1);
            check_gun();
        end

        for (k = 0; k < 6; k++) begin
            clear_column(k);
        end
        wait_game_over(10);
        check_score();

        press_start();
        score_exp = 0;
        alive_exp = '1;
        gun_exp   = 290;
        check_score();
        check_value("game over after restart", 0, int'(game_over_o));
        check_targets();
        check_gun();

        $display("All tests passed");
        $finish;
    end

endmodule
